// ==== Bender.yml ====
package:
  name: fetch_frontend

sources:
  - files:
      - design/rv_fe_pkg.sv
      - design/btb_update_if.sv
      - design/btb.sv
      - design/ras.sv
      - design/pc_gen.sv
      - design/fetch_frontend.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/clk_gen.sv
      - sim/tb_fetch_frontend.sv

// ==== design/btb.sv ====
`timescale 1ns/10ps

module btb
  import rv_fe_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  pc_t               lookup_pc,
  output btb_pred_t         pred,
  btb_update_if.sink        upd
);

  // ------------------------------------------------------------------
  // Entry storage
  // ------------------------------------------------------------------

  // Valid bits are control state, the rest is payload
  logic [BTB_ENTRIES-1:0] valid_q;
  logic [BTB_TAG_W-1:0]   tag_q [BTB_ENTRIES];
  pc_t                    tgt_q [BTB_ENTRIES];
  ctr_t                   ctr_q [BTB_ENTRIES];
  logic                   ret_q [BTB_ENTRIES];
  logic                   jal_q [BTB_ENTRIES];

  // Lookup side index and tag
  logic [BTB_IDX_W-1:0] lk_idx;
  logic [BTB_TAG_W-1:0] lk_tag;
  logic                 lk_hit;

  // Update side index and tag
  logic [BTB_IDX_W-1:0] up_idx;
  logic [BTB_TAG_W-1:0] up_tag;
  logic                 up_hit;

  // Saturating step of a taken counter
  function automatic ctr_t ctr_step(ctr_t c, logic taken);
    ctr_t n;
    n = c;
    if (taken && (c != 2'd3)) begin
      n = c + 2'd1;
    end else if (!taken && (c != 2'd0)) begin
      n = c - 2'd1;
    end
    return n;
  endfunction

  // ------------------------------------------------------------------
  // Lookup
  // ------------------------------------------------------------------

  assign lk_idx = lookup_pc[BTB_IDX_LSB +: BTB_IDX_W];
  assign lk_tag = lookup_pc[XLEN-1 -: BTB_TAG_W];
  assign lk_hit = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);

  always_comb begin
    pred.hit       = lk_hit;
    // Counter upper bit or an unconditional jump predicts taken
    pred.taken     = lk_hit && (ctr_q[lk_idx][1] || jal_q[lk_idx]);
    pred.is_return = lk_hit && ret_q[lk_idx];
    pred.tgt       = tgt_q[lk_idx];
  end

  // ------------------------------------------------------------------
  // Update
  // ------------------------------------------------------------------

  assign up_idx = upd.pc[BTB_IDX_LSB +: BTB_IDX_W];
  assign up_tag = upd.pc[XLEN-1 -: BTB_TAG_W];
  assign up_hit = valid_q[up_idx] && (tag_q[up_idx] == up_tag);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (upd.en) begin
      valid_q[up_idx] <= 1'b1;
    end
  end

  // Written at edge N, seen by lookups from cycle N+1
  always_ff @(posedge clk) begin
    if (upd.en) begin
      tgt_q[up_idx] <= upd.tgt;
      ret_q[up_idx] <= upd.is_ret;
      if (up_hit) begin
        // Same branch again, tag stays, counter trains
        ctr_q[up_idx] <= ctr_step(ctr_q[up_idx], upd.taken);
      end else begin
        // New branch takes over the slot
        tag_q[up_idx] <= up_tag;
        jal_q[up_idx] <= upd.is_jal;
        ctr_q[up_idx] <= upd.taken ? CTR_WEAK_TAKEN : CTR_WEAK_NOT;
      end
    end
  end

  // Back end must hand over clean fields with every strobe
  a_upd_known : assert property (
    @(posedge upd.clk) disable iff (!rst_n)
    upd.en |-> !$isunknown({upd.pc, upd.tgt, upd.taken, upd.is_ret, upd.is_jal})
  ) else $error("btb: unknown update fields with en high");

endmodule

// ==== design/btb_update_if.sv ====
`timescale 1ns/10ps

// One BTB update per strobe, no handshake
interface btb_update_if
  import rv_fe_pkg::*;
(
  input logic clk
);

  logic en;
  pc_t  pc;
  pc_t  tgt;
  logic taken;
  logic is_ret;
  logic is_jal;

  // Back end side, driven from the top-level ports
  modport src(input clk, output en, pc, tgt, taken, is_ret, is_jal);

  // BTB side
  modport sink(input clk, input en, pc, tgt, taken, is_ret, is_jal);

endinterface

// ==== design/fetch_frontend.sv ====
`timescale 1ns/10ps

module fetch_frontend
  import rv_fe_pkg::*;
(
  input  logic clk,
  input  logic rst_n,

  // Stalls and instruction memory
  input  logic stall,
  input  logic imem_stall,
  output logic imem_ren,
  output pc_t  imem_raddr,

  // Redirect from the back end
  input  logic redir_valid,
  input  pc_t  redir_tgt,

  // BTB training from the back end
  input  logic btb_upd_en,
  input  pc_t  btb_upd_pc,
  input  pc_t  btb_upd_tgt,
  input  logic btb_upd_taken,
  input  logic btb_upd_is_ret,
  input  logic btb_upd_is_jal,

  // Call seen by the back end
  input  logic ras_push_en,
  input  pc_t  ras_push_addr
);

  pc_t       pc;
  logic      fetch_en;
  btb_pred_t pred;
  logic      ras_valid;
  pc_t       ras_tgt;
  logic      ras_pop_en;

  btb_update_if btb_upd (.clk(clk));

  // ------------------------------------------------------------------
  // Update bundle from plain ports
  // ------------------------------------------------------------------

  assign btb_upd.en     = btb_upd_en;
  assign btb_upd.pc     = btb_upd_pc;
  assign btb_upd.tgt    = btb_upd_tgt;
  assign btb_upd.taken  = btb_upd_taken;
  assign btb_upd.is_ret = btb_upd_is_ret;
  assign btb_upd.is_jal = btb_upd_is_jal;

  // ------------------------------------------------------------------
  // Units
  // ------------------------------------------------------------------

  pc_gen u_pc_gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall      (stall),
    .imem_stall (imem_stall),
    .redir_valid(redir_valid),
    .redir_tgt  (redir_tgt),
    .pred       (pred),
    .ras_valid  (ras_valid),
    .ras_tgt    (ras_tgt),
    .pc         (pc),
    .fetch_en   (fetch_en),
    .pop_en     (ras_pop_en)
  );

  // Lookup runs off the registered PC
  btb u_btb (
    .clk      (clk),
    .rst_n    (rst_n),
    .lookup_pc(pc),
    .pred     (pred),
    .upd      (btb_upd)
  );

  ras u_ras (
    .clk      (clk),
    .rst_n    (rst_n),
    .push_en  (ras_push_en),
    .push_addr(ras_push_addr),
    .pop_en   (ras_pop_en),
    .ras_valid(ras_valid),
    .ras_tgt  (ras_tgt)
  );

  // SRAM-style fetch, address is the PC itself
  assign imem_ren   = fetch_en;
  assign imem_raddr = pc;

endmodule

// ==== design/pc_gen.sv ====
`timescale 1ns/10ps

module pc_gen
  import rv_fe_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      stall,
  input  logic      imem_stall,
  input  logic      redir_valid,
  input  pc_t       redir_tgt,
  input  btb_pred_t pred,
  input  logic      ras_valid,
  input  pc_t       ras_tgt,
  output pc_t       pc,
  output logic      fetch_en,
  output logic      pop_en
);

  // Set once RESET_PC has been presented with fetch enabled
  logic fetch_started;

  logic hold;
  logic advance;
  logic sel_ras;
  logic sel_btb;
  pc_t  pc_plus4;
  pc_t  pc_next;

  // ------------------------------------------------------------------
  // Advance rules
  // ------------------------------------------------------------------

  assign hold = stall || imem_stall;

  // Redirect wins over any stall
  // First fetch after reset keeps RESET_PC for one more edge
  assign advance = redir_valid || (fetch_started && !hold);

  // ------------------------------------------------------------------
  // Next PC priority
  // ------------------------------------------------------------------

  assign pc_plus4 = pc + pc_t'(4);

  // Return with a live stack entry
  assign sel_ras = !redir_valid && pred.hit && pred.is_return && ras_valid;

  // Taken BTB hit, also a return once the stack ran dry
  assign sel_btb = !redir_valid && !sel_ras && pred.hit && pred.taken;

  always_comb begin
    if (redir_valid) begin
      pc_next = redir_tgt;
    end else if (sel_ras) begin
      pc_next = ras_tgt;
    end else if (sel_btb) begin
      pc_next = pred.tgt;
    end else begin
      pc_next = pc_plus4;
    end
  end

  // Consume the stack entry only when the PC actually moves
  assign pop_en = sel_ras && advance;

  // ------------------------------------------------------------------
  // PC and fetch enable registers
  // ------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc            <= RESET_PC;
      fetch_en      <= 1'b0;
      fetch_started <= 1'b0;
    end else begin
      fetch_started <= 1'b1;
      // Low after a stalled cycle unless a redirect came in
      fetch_en      <= !hold || redir_valid;
      if (advance) begin
        pc <= pc_next;
      end
    end
  end

  // Redirects and predictions must keep instructions word aligned
  a_pc_aligned : assert property (
    @(posedge clk) disable iff (!rst_n)
    pc[1:0] == 2'b00
  ) else $error("pc_gen: misaligned fetch PC %h", pc);

endmodule

// ==== design/ras.sv ====
`timescale 1ns/10ps

module ras
  import rv_fe_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic push_en,
  input  pc_t  push_addr,
  input  logic pop_en,
  output logic ras_valid,
  output pc_t  ras_tgt
);

  // Circular storage, top_q points at the newest entry
  pc_t                  stack_q [RAS_DEPTH];
  logic [RAS_PTR_W-1:0] top_q;
  logic [RAS_PTR_W-1:0] top_inc;
  logic [RAS_PTR_W-1:0] top_dec;
  logic [RAS_CNT_W-1:0] cnt_q;

  // Pointer wraps at the stack depth
  assign top_inc = top_q + RAS_PTR_W'(1);
  assign top_dec = top_q - RAS_PTR_W'(1);

  assign ras_valid = (cnt_q != '0);
  assign ras_tgt   = stack_q[top_q];

  // ------------------------------------------------------------------
  // Pointer and occupancy
  // ------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      top_q <= '0;
      cnt_q <= '0;
    end else begin
      case ({push_en, pop_en})
        2'b10: begin
          top_q <= top_inc;
          // Full stack drops its oldest entry, count stays at depth
          if (cnt_q != RAS_CNT_W'(RAS_DEPTH)) begin
            cnt_q <= cnt_q + RAS_CNT_W'(1);
          end
        end
        2'b01: begin
          top_q <= top_dec;
          cnt_q <= cnt_q - RAS_CNT_W'(1);
        end
        default: begin
          // Idle, or push with pop which only swaps the top
          top_q <= top_q;
          cnt_q <= cnt_q;
        end
      endcase
    end
  end

  // ------------------------------------------------------------------
  // Entry writes
  // ------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (push_en && pop_en) begin
      stack_q[top_q] <= push_addr;
    end else if (push_en) begin
      stack_q[top_inc] <= push_addr;
    end
  end

  // Fetch side only pops what it saw as a valid return target
  a_no_pop_empty : assert property (
    @(posedge clk) disable iff (!rst_n)
    pop_en |-> ras_valid
  ) else $error("ras: pop with empty stack");

endmodule

// ==== design/rv_fe_pkg.sv ====
package rv_fe_pkg;

  // ------------------------------------------------------------------
  // Address and PC
  // ------------------------------------------------------------------

  // RV32I address width
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] pc_t;

  // First fetch address after reset
  localparam pc_t RESET_PC = 32'h0000_0000;

  // ------------------------------------------------------------------
  // Branch target buffer
  // ------------------------------------------------------------------

  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W   = 4;
  localparam int BTB_TAG_W   = 26;

  // Index sits just above the byte offset, tag takes the rest
  localparam int BTB_IDX_LSB = 2;

  // 2-bit saturating counter, upper bit set means taken
  typedef logic [1:0] ctr_t;

  localparam ctr_t CTR_WEAK_TAKEN = 2'd2;
  localparam ctr_t CTR_WEAK_NOT   = 2'd1;

  // One lookup result, combinational from the fetch PC
  typedef struct packed {
    logic hit;
    logic taken;
    logic is_return;
    pc_t  tgt;
  } btb_pred_t;

  // ------------------------------------------------------------------
  // Return address stack
  // ------------------------------------------------------------------

  localparam int RAS_DEPTH = 8;
  localparam int RAS_PTR_W = 3;

  // Occupancy runs 0..RAS_DEPTH, so one more bit than the pointer
  localparam int RAS_CNT_W = RAS_PTR_W + 1;

endpackage

// ==== fetch_frontend.f ====
+incdir+sim
design/rv_fe_pkg.sv
design/btb_update_if.sv
design/btb.sv
design/ras.sv
design/pc_gen.sv
design/fetch_frontend.sv
sim/clk_gen.sv
sim/tb_fetch_frontend.sv

// ==== sim/clk_gen.sv ====
`timescale 1ns/10ps

module clk_gen (
  output logic clk,
  output logic rst_n
);

  // 100 ns clock period
  localparam int HALF_PERIOD_NS = 50;
  localparam int RESET_CYCLES   = 16;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  // Synchronous reset, released on a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== sim/fe_tests.svh ====
`ifndef FE_TESTS_SVH
`define FE_TESTS_SVH

// ------------------------------------------------------------------
// Drive and check helpers
// ------------------------------------------------------------------

// Outputs are compared on the falling edge, away from the drive edge
task automatic expect_fetch(input pc_t exp_addr, input logic exp_ren, input string what);
  check_cnt++;
  assert (imem_raddr === exp_addr && imem_ren === exp_ren)
  else begin
    err_cnt++;
    $display("FAILED at %0t: %s, got addr %h ren %b, expected addr %h ren %b",
             $time, what, imem_raddr, imem_ren, exp_addr, exp_ren);
  end
endtask

// One rising edge with no new stimulus, then the sample point
task automatic advance_cycle();
  @(posedge clk);
  @(negedge clk);
endtask

task automatic report_test(input string name, input int errs_before);
  test_cnt++;
  if (err_cnt != errs_before) begin
    failed_test_cnt++;
  end
  $display("%-20s %s, %0d failed checks", name,
           (err_cnt == errs_before) ? "passed" : "has errors", err_cnt - errs_before);
endtask

// Update is written at the second edge
task automatic send_btb_update(input pc_t pc, input pc_t tgt, input logic taken,
                               input logic is_ret, input logic is_jal);
  @(posedge clk);
  btb_upd_en     <= 1'b1;
  btb_upd_pc     <= pc;
  btb_upd_tgt    <= tgt;
  btb_upd_taken  <= taken;
  btb_upd_is_ret <= is_ret;
  btb_upd_is_jal <= is_jal;
  @(posedge clk);
  btb_upd_en <= 1'b0;
endtask

task automatic push_return(input pc_t addr);
  @(posedge clk);
  ras_push_en   <= 1'b1;
  ras_push_addr <= addr;
  @(posedge clk);
  ras_push_en <= 1'b0;
endtask

// Target shows up the cycle after the redirect strobe
task automatic redirect_to(input pc_t addr);
  @(posedge clk);
  redir_valid <= 1'b1;
  redir_tgt   <= addr;
  @(posedge clk);
  redir_valid <= 1'b0;
  @(negedge clk);
  expect_fetch(addr, 1'b1, "redirect lands on target");
endtask

// ------------------------------------------------------------------
// Directed tests
// ------------------------------------------------------------------

task automatic test_reset_sequential();
  int  errs_before;
  pc_t exp_addr;
  errs_before = err_cnt;
  // First edge loads the reset values
  @(posedge clk);
  @(negedge clk);
  while (rst_n !== 1'b1) begin
    expect_fetch(RESET_PC, 1'b0, "held in reset");
    @(negedge clk);
  end
  // Edge that sees rst_n high turns fetch on at RESET_PC
  advance_cycle();
  expect_fetch(RESET_PC, 1'b1, "first fetch after reset");
  exp_addr = RESET_PC;
  repeat (SEQ_STEPS) begin
    exp_addr = exp_addr + 4;
    advance_cycle();
    expect_fetch(exp_addr, 1'b1, "sequential fetch");
  end
  report_test("reset_sequential", errs_before);
endtask

task automatic test_stall_redirect();
  int  errs_before;
  pc_t cur;
  pc_t tgt;
  errs_before = err_cnt;
  tgt = random_word_addr();
  @(negedge clk);
  cur = imem_raddr;
  @(posedge clk);
  stall <= 1'b1;
  @(negedge clk);
  cur = cur + 4;
  expect_fetch(cur, 1'b1, "last advance before stall");
  repeat (3) begin
    advance_cycle();
    expect_fetch(cur, 1'b0, "stall holds address");
  end
  // Hand over from core stall to memory stall
  @(posedge clk);
  stall      <= 1'b0;
  imem_stall <= 1'b1;
  @(negedge clk);
  expect_fetch(cur, 1'b0, "stall holds address");
  advance_cycle();
  expect_fetch(cur, 1'b0, "imem_stall holds address");
  // Redirect inside a stalled cycle
  @(posedge clk);
  redir_valid <= 1'b1;
  redir_tgt   <= tgt;
  @(negedge clk);
  expect_fetch(cur, 1'b0, "imem_stall holds address");
  @(posedge clk);
  redir_valid <= 1'b0;
  @(negedge clk);
  expect_fetch(tgt, 1'b1, "redirect overrides stall");
  advance_cycle();
  expect_fetch(tgt, 1'b0, "stall holds redirect target");
  @(posedge clk);
  imem_stall <= 1'b0;
  @(negedge clk);
  expect_fetch(tgt, 1'b0, "stall holds redirect target");
  advance_cycle();
  expect_fetch(tgt + 4, 1'b1, "fetch resumes after stall");
  report_test("stall_redirect", errs_before);
endtask

task automatic test_btb_taken();
  int  errs_before;
  pc_t br_pc;
  pc_t br_tgt;
  pc_t jal_pc;
  pc_t jal_tgt;
  errs_before = err_cnt;
  br_pc   = 32'h0000_2048;
  br_tgt  = 32'h0000_3000;
  jal_pc  = 32'h0000_4050;
  jal_tgt = 32'h0000_a000;
  // New entry starts weakly taken
  send_btb_update(br_pc, br_tgt, 1'b1, 1'b0, 1'b0);
  redirect_to(br_pc);
  advance_cycle();
  expect_fetch(br_tgt, 1'b1, "BTB taken prediction");
  // Train down to not taken
  send_btb_update(br_pc, br_tgt, 1'b0, 1'b0, 1'b0);
  send_btb_update(br_pc, br_tgt, 1'b0, 1'b0, 1'b0);
  redirect_to(br_pc);
  advance_cycle();
  expect_fetch(br_pc + 4, 1'b1, "not-taken branch falls through");
  // A JAL stays taken whatever the counter says
  send_btb_update(jal_pc, jal_tgt, 1'b0, 1'b0, 1'b1);
  send_btb_update(jal_pc, jal_tgt, 1'b0, 1'b0, 1'b1);
  send_btb_update(jal_pc, jal_tgt, 1'b0, 1'b0, 1'b1);
  redirect_to(jal_pc);
  advance_cycle();
  expect_fetch(jal_tgt, 1'b1, "JAL entry always taken");
  report_test("btb_taken", errs_before);
endtask

task automatic test_btb_tag_check();
  int  errs_before;
  pc_t br_pc;
  pc_t br_tgt;
  pc_t other;
  errs_before = err_cnt;
  br_pc  = 32'h0000_2048;
  br_tgt = 32'h0000_3000;
  other  = alias_of(br_pc);
  // Counter back up to weak taken
  send_btb_update(br_pc, br_tgt, 1'b1, 1'b0, 1'b0);
  send_btb_update(br_pc, br_tgt, 1'b1, 1'b0, 1'b0);
  redirect_to(br_pc);
  advance_cycle();
  expect_fetch(br_tgt, 1'b1, "retrained branch taken");
  redirect_to(other);
  advance_cycle();
  expect_fetch(other + 4, 1'b1, "tag mismatch stays sequential");
  report_test("btb_tag_check", errs_before);
endtask

task automatic test_return_prediction();
  int  errs_before;
  pc_t ret_a;
  pc_t ret_b;
  pc_t ret_pc;
  pc_t ret_btb_tgt;
  errs_before = err_cnt;
  ret_a       = 32'h0000_8100;
  ret_b       = 32'h0000_9200;
  ret_pc      = 32'h0000_6060;
  ret_btb_tgt = 32'h0000_7000;
  push_return(ret_a);
  push_return(ret_b);
  send_btb_update(ret_pc, ret_btb_tgt, 1'b1, 1'b1, 1'b0);
  // Stack pops newest first
  redirect_to(ret_pc);
  advance_cycle();
  expect_fetch(ret_b, 1'b1, "return to newest call");
  redirect_to(ret_pc);
  advance_cycle();
  expect_fetch(ret_a, 1'b1, "return to older call");
  // Empty stack, BTB target used instead
  redirect_to(ret_pc);
  advance_cycle();
  expect_fetch(ret_btb_tgt, 1'b1, "empty stack uses BTB target");
  report_test("return_prediction", errs_before);
endtask

`endif

// ==== sim/tb_fetch_frontend.sv ====
`timescale 1ns/10ps

module tb_fetch_frontend
  import rv_fe_pkg::*;
();

  // ------------------------------------------------------------------
  // Run length
  // ------------------------------------------------------------------

  localparam int CLK_PERIOD_NS = 100;
  localparam int RESET_CYCLES  = 16;
  localparam int SEQ_STEPS     = 8;

  // Cycle budget of each directed test
  localparam int BUDGET_RESET_SEQ  = 20;
  localparam int BUDGET_STALL      = 30;
  localparam int BUDGET_BTB_TAKEN  = 40;
  localparam int BUDGET_BTB_TAG    = 20;
  localparam int BUDGET_RETURN     = 30;
  localparam int TOTAL_BUDGET = BUDGET_RESET_SEQ + BUDGET_STALL + BUDGET_BTB_TAKEN
                                + BUDGET_BTB_TAG + BUDGET_RETURN;

  logic clk;
  logic rst_n;

  // DUT inputs
  logic stall;
  logic imem_stall;
  logic redir_valid;
  pc_t  redir_tgt;
  logic btb_upd_en;
  pc_t  btb_upd_pc;
  pc_t  btb_upd_tgt;
  logic btb_upd_taken;
  logic btb_upd_is_ret;
  logic btb_upd_is_jal;
  logic ras_push_en;
  pc_t  ras_push_addr;

  // DUT outputs
  logic imem_ren;
  pc_t  imem_raddr;

  // Bookkeeping
  integer seed;
  int     err_cnt;
  int     check_cnt;
  int     test_cnt;
  int     failed_test_cnt;

  clk_gen u_clk_gen (
    .clk  (clk),
    .rst_n(rst_n)
  );

  fetch_frontend uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall         (stall),
    .imem_stall    (imem_stall),
    .imem_ren      (imem_ren),
    .imem_raddr    (imem_raddr),
    .redir_valid   (redir_valid),
    .redir_tgt     (redir_tgt),
    .btb_upd_en    (btb_upd_en),
    .btb_upd_pc    (btb_upd_pc),
    .btb_upd_tgt   (btb_upd_tgt),
    .btb_upd_taken (btb_upd_taken),
    .btb_upd_is_ret(btb_upd_is_ret),
    .btb_upd_is_jal(btb_upd_is_jal),
    .ras_push_en   (ras_push_en),
    .ras_push_addr (ras_push_addr)
  );

  // ------------------------------------------------------------------
  // Reference helpers
  // ------------------------------------------------------------------

  // Same BTB index (bits 5:2), different tag
  function automatic pc_t alias_of(input pc_t addr);
    return addr ^ 32'h0001_0000;
  endfunction

  // Random fetch target on a word boundary
  function automatic pc_t random_word_addr();
    pc_t raw;
    raw = pc_t'($random(seed));
    return raw & 32'hffff_fffc;
  endfunction

  `include "fe_tests.svh"

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------

  initial begin
    stall          = 1'b0;
    imem_stall     = 1'b0;
    redir_valid    = 1'b0;
    redir_tgt      = '0;
    btb_upd_en     = 1'b0;
    btb_upd_pc     = '0;
    btb_upd_tgt    = '0;
    btb_upd_taken  = 1'b0;
    btb_upd_is_ret = 1'b0;
    btb_upd_is_jal = 1'b0;
    ras_push_en    = 1'b0;
    ras_push_addr  = '0;
    seed            = 32'hf0021970;
    err_cnt         = 0;
    check_cnt       = 0;
    test_cnt        = 0;
    failed_test_cnt = 0;

    test_reset_sequential();
    test_stall_redirect();
    test_btb_taken();
    test_btb_tag_check();
    test_return_prediction();

    $display("Tests %0d, failing tests %0d, checks %0d, failed checks %0d",
             test_cnt, failed_test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Ends a hung run after reset plus all test budgets
  initial begin
    #((RESET_CYCLES + TOTAL_BUDGET) * CLK_PERIOD_NS);
    $display("Watchdog expired after %0d cycles, the tests did not finish",
             RESET_CYCLES + TOTAL_BUDGET);
    $display("Test failed");
    $finish;
  end

endmodule
